// File: src/div_consts.svh
// Divide unit constants
`ifndef DIV_CONSTS_SVH
`define DIV_CONSTS_SVH

//////////////////////////////////////////////////
// Datapath

// Operand and result width
`define DIV_XLEN 32

// Instruction id carried to writeback
`define DIV_ID_W 3

//////////////////////////////////////////////////
// Queue

// Entries in the request queue, power of two
`define DIV_QUEUE_DEPTH 4

`endif

// File: src/div_pkg.sv
// Divide unit types
`include "div_consts.svh"

package div_pkg;

    //////////////////////////////////////////////////
    // Opcodes

    // Bit 0 set means unsigned
    // Bit 1 set means remainder
    typedef enum logic [1:0] {
        DIV  = 2'b00,
        DIVU = 2'b01,
        REM  = 2'b10,
        REMU = 2'b11
    } div_op_e;

    // Iterative divider states
    typedef enum logic {
        IDLE = 1'b0,
        BUSY = 1'b1
    } div_state_e;

    // Writeback tag
    typedef logic [`DIV_ID_W-1:0] div_id_t;

    //////////////////////////////////////////////////
    // Queue entry

    // Magnitudes plus what the result stage needs to restore signs
    typedef struct packed {
        logic [`DIV_XLEN-1:0] dividend;
        logic [`DIV_XLEN-1:0] divisor;
        logic                 rem_op;
        logic                 negate_quotient;
        logic                 negate_remainder;
        div_id_t              id;
    } div_entry_t;

endpackage

// File: src/div_queue_if.sv
// Queue to divider link
`timescale 1ns/10ps
`include "div_consts.svh"

interface div_queue_if;

    // Head of the queue
    logic                 head_valid;
    div_pkg::div_entry_t  head_entry;
    // Head retire strobe from the divider
    logic                 pop;

    // Divider results for the result stage
    logic                 done;
    logic [`DIV_XLEN-1:0] quotient;
    logic [`DIV_XLEN-1:0] remainder;
    logic                 divisor_zero;

    modport queue (output head_valid, output head_entry, input pop);

    modport core (input head_valid, input head_entry, output pop, output done,
                  output quotient, output remainder, output divisor_zero);

    // Read only view for writeback
    modport result (input head_entry, input done, input quotient, input remainder,
                    input divisor_zero);

endinterface

// File: src/div_decode.sv
// Divide operand decode
`timescale 1ns/10ps
`include "div_consts.svh"

module div_decode (
    input  div_pkg::div_op_e     issue_op,
    input  logic [`DIV_XLEN-1:0] issue_rs1,
    input  logic [`DIV_XLEN-1:0] issue_rs2,
    input  div_pkg::div_id_t     issue_id,
    output div_pkg::div_entry_t  entry
);

    // Opcode meanings
    logic signed_op;
    logic rem_op;

    // Operand sign bits
    logic rs1_neg;
    logic rs2_neg;

    // Negate flags
    logic negate_dividend;
    logic negate_divisor;
    logic negate_quotient;
    logic negate_remainder;

    // Magnitudes fed to the unsigned core
    logic [`DIV_XLEN-1:0] dividend_mag;
    logic [`DIV_XLEN-1:0] divisor_mag;

    //////////////////////////////////////////////////
    // Opcode split

    // Low bit clear means signed
    assign signed_op = ~issue_op[0];
    assign rem_op    = issue_op[1];

    assign rs1_neg = issue_rs1[`DIV_XLEN-1];
    assign rs2_neg = issue_rs2[`DIV_XLEN-1];

    //////////////////////////////////////////////////
    // Sign handling

    // Only signed ops care about the top bits
    assign negate_dividend  = signed_op & rs1_neg;
    assign negate_divisor   = signed_op & rs2_neg;
    // Quotient sign follows the operand sign mismatch
    assign negate_quotient  = signed_op & (rs1_neg ^ rs2_neg);
    // Remainder takes the dividend sign
    assign negate_remainder = signed_op & rs1_neg;

    //////////////////////////////////////////////////
    // Operand conditioning

    // Conditional two's complement
    // Most negative value maps onto itself which is the right magnitude
    assign dividend_mag = ({`DIV_XLEN{negate_dividend}} ^ issue_rs1) +
                          `DIV_XLEN'(negate_dividend);
    assign divisor_mag  = ({`DIV_XLEN{negate_divisor}} ^ issue_rs2) +
                          `DIV_XLEN'(negate_divisor);

    // Pack the queue entry
    assign entry.dividend         = dividend_mag;
    assign entry.divisor          = divisor_mag;
    assign entry.rem_op           = rem_op;
    assign entry.negate_quotient  = negate_quotient;
    assign entry.negate_remainder = negate_remainder;
    assign entry.id               = issue_id;

endmodule

// File: src/div_queue.sv
// Divide request queue
`timescale 1ns/10ps
`include "div_consts.svh"

module div_queue (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  logic                push,
    input  div_pkg::div_entry_t entry,
    output logic                ready,
    div_queue_if.queue          q
);

    localparam int PTR_W = $clog2(`DIV_QUEUE_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    // Entry storage
    div_pkg::div_entry_t mem [`DIV_QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic full;
    logic push_ok;
    logic pop_ok;

    //////////////////////////////////////////////////
    // Occupancy

    assign full  = (count == CNT_W'(`DIV_QUEUE_DEPTH));
    // Ready drops only when full
    assign ready = ~full;

    // Flush kills the request in the same cycle
    assign push_ok = push & ~flush & ~full;
    assign pop_ok  = q.pop & (count != '0);

    // Pointers wrap on their own for power of two depths
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop_ok)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + CNT_W'(push_ok) - CNT_W'(pop_ok);
        end
    end

    // Storage write
    always_ff @(posedge clk) begin
        if (push_ok)
            mem[wr_ptr] <= entry;
    end

    //////////////////////////////////////////////////
    // Head

    // Head stays put until the divider pops it
    assign q.head_valid = (count != '0);
    assign q.head_entry = mem[rd_ptr];

    // Issue side must hold off while full
    no_push_full : assert property (@(posedge clk) disable iff (rst)
        (push & ~flush) |-> ready)
        else $error("div_queue: push while full");

    // Divider only retires a head that exists
    no_pop_empty : assert property (@(posedge clk) disable iff (rst)
        q.pop |-> q.head_valid)
        else $error("div_queue: pop while empty");

endmodule

// File: src/div_radix2_core.sv
// Radix-2 restoring divider
`timescale 1ns/10ps
`include "div_consts.svh"

module div_radix2_core (
    input logic       clk,
    input logic       rst,
    div_queue_if.core q
);

    localparam int STEP_W = $clog2(`DIV_XLEN);

    div_pkg::div_state_e state;

    // Iteration count and end marker
    logic [STEP_W-1:0] step;
    logic              last;

    // Partial remainder and quotient shift register
    logic [`DIV_XLEN-1:0] rem_r;
    logic [`DIV_XLEN-1:0] quo_r;
    logic                 zero_r;

    // One subtract step
    logic [`DIV_XLEN:0] partial;
    logic [`DIV_XLEN:0] diff;

    logic start;
    logic iterate;
    logic done;

    //////////////////////////////////////////////////
    // Control

    assign start   = (state == div_pkg::IDLE) & q.head_valid;
    assign iterate = (state == div_pkg::BUSY) & ~last;
    // Done in the cycle after the last iteration
    assign done    = (state == div_pkg::BUSY) & last;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= div_pkg::IDLE;
            step  <= '0;
            last  <= 1'b0;
        end else begin
            case (state)
                div_pkg::IDLE: begin
                    if (q.head_valid) begin
                        state <= div_pkg::BUSY;
                        step  <= '0;
                        last  <= 1'b0;
                    end
                end
                div_pkg::BUSY: begin
                    if (last) begin
                        state <= div_pkg::IDLE;
                        last  <= 1'b0;
                    end else begin
                        step <= step + 1'b1;
                        // 32nd iteration
                        if (step == STEP_W'(`DIV_XLEN - 1))
                            last <= 1'b1;
                    end
                end
                default: state <= div_pkg::IDLE;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Datapath

    // Shift in the next dividend bit and trial subtract
    assign partial = {rem_r, quo_r[`DIV_XLEN-1]};
    assign diff    = partial - {1'b0, q.head_entry.divisor};

    // Zero divisor never borrows so quotient fills with ones
    always_ff @(posedge clk) begin
        if (start) begin
            rem_r  <= '0;
            quo_r  <= q.head_entry.dividend;
            zero_r <= (q.head_entry.divisor == '0);
        end else if (iterate) begin
            if (diff[`DIV_XLEN]) begin
                // Borrow so restore
                rem_r <= partial[`DIV_XLEN-1:0];
                quo_r <= {quo_r[`DIV_XLEN-2:0], 1'b0};
            end else begin
                rem_r <= diff[`DIV_XLEN-1:0];
                quo_r <= {quo_r[`DIV_XLEN-2:0], 1'b1};
            end
        end
    end

    // Outputs to queue and result stage
    assign q.done         = done;
    assign q.pop          = done;
    assign q.quotient     = quo_r;
    assign q.remainder    = rem_r;
    assign q.divisor_zero = zero_r;

    // Head must stay valid across the whole division
    done_with_head : assert property (@(posedge clk) disable iff (rst)
        done |-> (state == div_pkg::BUSY) && q.head_valid)
        else $error("div_radix2_core: done without a valid head");

    // Fixed start to done latency
    start_to_done : assert property (@(posedge clk) disable iff (rst)
        start |-> ##33 done)
        else $error("div_radix2_core: done not 33 cycles after start");

endmodule

// File: src/div_result.sv
// Divide result and writeback
`timescale 1ns/10ps
`include "div_consts.svh"

module div_result (
    div_queue_if.result          q,
    output logic                 wb_done,
    output div_pkg::div_id_t     wb_id,
    output logic [`DIV_XLEN-1:0] wb_rd
);

    logic                 rem_op;
    logic                 negate;
    logic [`DIV_XLEN-1:0] magnitude;

    //////////////////////////////////////////////////
    // Select

    assign rem_op = q.head_entry.rem_op;

    // Zero divisor already leaves an all ones quotient in the core
    assign magnitude = rem_op ? q.remainder : q.quotient;

    //////////////////////////////////////////////////
    // Sign fix-up

    // All ones quotient on zero divisor keeps its sign
    // Remainder still follows the dividend
    assign negate = rem_op ? q.head_entry.negate_remainder
                           : (q.head_entry.negate_quotient & ~q.divisor_zero);

    // Conditional two's complement
    assign wb_rd = ({`DIV_XLEN{negate}} ^ magnitude) + `DIV_XLEN'(negate);

    //////////////////////////////////////////////////
    // Writeback

    // Same cycle as the core done
    assign wb_done = q.done;
    assign wb_id   = q.head_entry.id;

endmodule

// File: src/div_unit.sv
// Integer divide unit top
`timescale 1ns/10ps
`include "div_consts.svh"

module div_unit (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 flush,

    // Issue side
    input  logic                 issue_valid,
    input  div_pkg::div_op_e     issue_op,
    input  logic [`DIV_XLEN-1:0] issue_rs1,
    input  logic [`DIV_XLEN-1:0] issue_rs2,
    input  div_pkg::div_id_t     issue_id,
    output logic                 issue_ready,

    // Writeback side
    output logic                 wb_done,
    output div_pkg::div_id_t     wb_id,
    output logic [`DIV_XLEN-1:0] wb_rd
);

    // Decoded request
    div_pkg::div_entry_t entry;

    // Queue head link
    div_queue_if q_if ();

    //////////////////////////////////////////////////
    // Decode stage

    div_decode u_decode (
        .issue_op  (issue_op),
        .issue_rs1 (issue_rs1),
        .issue_rs2 (issue_rs2),
        .issue_id  (issue_id),
        .entry     (entry)
    );

    //////////////////////////////////////////////////
    // Execute stage

    div_queue u_queue (
        .clk   (clk),
        .rst   (rst),
        .flush (flush),
        .push  (issue_valid),
        .entry (entry),
        .ready (issue_ready),
        .q     (q_if.queue)
    );

    div_radix2_core u_core (
        .clk (clk),
        .rst (rst),
        .q   (q_if.core)
    );

    //////////////////////////////////////////////////
    // Result stage

    div_result u_result (
        .q       (q_if.result),
        .wb_done (wb_done),
        .wb_id   (wb_id),
        .wb_rd   (wb_rd)
    );

endmodule

// File: bench/div_tb.sv
// Divide unit testbench
`timescale 1ns/10ps
`include "div_consts.svh"

module div_tb;

    //////////////////////////////////////////////////
    // Run length

    localparam int NUM_REQ        = 400;
    localparam int TIMEOUT_CYCLES = NUM_REQ * 40 + 1000;
    // Enough for a full queue plus the one in flight
    localparam int DRAIN_CYCLES   = (`DIV_QUEUE_DEPTH + 1) * 40;

    logic                 clk;
    logic                 rst;
    logic                 flush;
    logic                 issue_valid;
    div_pkg::div_op_e     issue_op;
    logic [`DIV_XLEN-1:0] issue_rs1;
    logic [`DIV_XLEN-1:0] issue_rs2;
    div_pkg::div_id_t     issue_id;
    logic                 issue_ready;
    logic                 wb_done;
    div_pkg::div_id_t     wb_id;
    logic [`DIV_XLEN-1:0] wb_rd;

    integer seed;

    // Expected writebacks in acceptance order
    logic [`DIV_XLEN-1:0] exp_rd_q [$];
    div_pkg::div_id_t     exp_id_q [$];
    logic [`DIV_XLEN-1:0] exp_rd_front;
    div_pkg::div_id_t     exp_id_front;

    int accepted;
    int flushed;
    int checked;
    int drain_count;

    div_unit dut_i (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_rs1   (issue_rs1),
        .issue_rs2   (issue_rs2),
        .issue_id    (issue_id),
        .issue_ready (issue_ready),
        .wb_done     (wb_done),
        .wb_id       (wb_id),
        .wb_rd       (wb_rd)
    );

    // 4 ns clock
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Failure and compare helpers

    task automatic stop_with_failure();
        $display("TEST RESULT: FAIL");
        $fatal(1, "div_tb stopped on the first error");
    endtask

    task automatic check_rd(logic [`DIV_XLEN-1:0] got, logic [`DIV_XLEN-1:0] exp,
                            string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s wb_rd got %h expected %h", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_id(div_pkg::div_id_t got, div_pkg::div_id_t exp, string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s wb_id got %0d expected %0d", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_level(logic got, logic exp, string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    //////////////////////////////////////////////////
    // Reference model

    // RISC-V M rules, zero divisor and overflow first
    function automatic logic [`DIV_XLEN-1:0] expected_rd(div_pkg::div_op_e op,
                                                         logic [`DIV_XLEN-1:0] a,
                                                         logic [`DIV_XLEN-1:0] b);
        logic                 signed_op;
        logic                 want_rem;
        logic [`DIV_XLEN-1:0] most_neg;
        logic [`DIV_XLEN-1:0] result;
        signed_op = (op == div_pkg::DIV) || (op == div_pkg::REM);
        want_rem  = (op == div_pkg::REM) || (op == div_pkg::REMU);
        most_neg  = {1'b1, {(`DIV_XLEN-1){1'b0}}};
        if (b == '0)
            result = want_rem ? a : '1;
        else if (signed_op && a == most_neg && b == '1)
            result = want_rem ? '0 : a;
        else if (signed_op && want_rem)
            result = $signed(a) % $signed(b);
        else if (signed_op)
            result = $signed(a) / $signed(b);
        else if (want_rem)
            result = a % b;
        else
            result = a / b;
        return result;
    endfunction

    //////////////////////////////////////////////////
    // Stimulus

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // One request with a random gap in front, held off while the queue is full
    task automatic issue_one(int n);
        logic [`DIV_XLEN-1:0] a;
        logic [`DIV_XLEN-1:0] b;
        logic [31:0]          sel;
        logic                 kill;
        div_pkg::div_op_e     op;
        int                   gap;
        a   = $random(seed);
        b   = $random(seed);
        sel = $random(seed);
        // Narrow divisors give quotients wider than a bit or two
        if (sel[3:2] != 2'd0)
            b = b >> sel[8:4];
        // About one in eight divisors is zero
        if (sel[11:9] == 3'd0)
            b = '0;
        else if (sel[15:12] == 4'd0) begin
            // Signed overflow pair
            a = {1'b1, {(`DIV_XLEN-1){1'b0}}};
            b = '1;
        end
        kill = (sel[19:16] == 4'd0);
        op   = div_pkg::div_op_e'(sel[21:20]);
        // Mostly back to back so bursts fill the queue
        gap  = (sel[24:22] < 3'd5) ? 0 : int'(sel[29:25]);
        repeat (gap) next_cycle();
        while (issue_ready !== 1'b1)
            next_cycle();
        issue_valid = 1'b1;
        flush       = kill;
        issue_op    = op;
        issue_rs1   = a;
        issue_rs2   = b;
        issue_id    = div_pkg::div_id_t'(n);
        if (kill) begin
            flushed++;
        end else begin
            accepted++;
            exp_rd_q.push_back(expected_rd(op, a, b));
            exp_id_q.push_back(div_pkg::div_id_t'(n));
        end
        next_cycle();
        issue_valid = 1'b0;
        flush       = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // Writeback monitor

    // Outputs sampled mid cycle
    always @(negedge clk) begin
        if (!rst && wb_done) begin
            if (exp_rd_q.size() == 0) begin
                $display("Error at %0t: writeback with no outstanding request", $time);
                stop_with_failure();
            end else begin
                exp_rd_front = exp_rd_q.pop_front();
                exp_id_front = exp_id_q.pop_front();
                check_id(wb_id, exp_id_front, "writeback order");
                check_rd(wb_rd, exp_rd_front, "writeback value");
                checked++;
            end
        end
    end

    // Hard limit on run length
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Error: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        stop_with_failure();
    end

    //////////////////////////////////////////////////
    // Main sequence

    initial begin
        seed        = 32'h6864_f9bf;
        rst         = 1'b1;
        flush       = 1'b0;
        issue_valid = 1'b0;
        issue_op    = div_pkg::DIV;
        issue_rs1   = '0;
        issue_rs2   = '0;
        issue_id    = '0;
        accepted    = 0;
        flushed     = 0;
        checked     = 0;
        drain_count = 0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        // Idle and ready before any request
        repeat (4) begin
            @(negedge clk);
            check_level(wb_done, 1'b0, "wb_done after reset");
            check_level(issue_ready, 1'b1, "issue_ready after reset");
        end
        next_cycle();

        for (int n = 0; n < NUM_REQ; n++)
            issue_one(n);

        // Let the queue empty, then watch for stray writebacks
        while (exp_rd_q.size() != 0 && drain_count < DRAIN_CYCLES) begin
            next_cycle();
            drain_count++;
        end
        repeat (40) next_cycle();

        if (exp_rd_q.size() != 0) begin
            $display("Error: %0d accepted requests were never written back", exp_rd_q.size());
            stop_with_failure();
        end else begin
            $display("%0d accepted, %0d flushed, %0d checked", accepted, flushed, checked);
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

// File: verilog.f
+incdir+src
src/div_pkg.sv
src/div_queue_if.sv
src/div_decode.sv
src/div_queue.sv
src/div_radix2_core.sv
src/div_result.sv
src/div_unit.sv
bench/div_tb.sv

// File: Makefile
# Verilator build and run for the divide unit testbench

VERILATOR ?= verilator
TOP       ?= div_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?=

BIN     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard src/*.sv src/*.svh bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Exit status of the simulation is the test verdict
run: $(BIN)
	$(BIN) $(RUN_ARGS)

clean:
	rm -rf $(BUILD_DIR)
